// ==== vlog.f ====
+incdir+rtl
+incdir+test
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/commit_stage.sv
rtl/core_top.sv
test/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Compile the core testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_core \
    -Mdir obj_dir -o sim_core &&
./obj_dir/sim_core ||
{ echo "run.sh: build or simulation returned an error"; exit 1; }

// ==== test/core_tests.svh ====
/*
 * Core directed tests
 * Instruction encoders, reference ALU and the test tasks,
 * included into the testbench module
 */
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

// --------------------
// Encoding and model
// --------------------
function automatic logic [2:0] funct3_of(input op_e op);
    case (op)
        OP_SLL:  return 3'b001;
        OP_SLT:  return 3'b010;
        OP_XOR:  return 3'b100;
        OP_SRL:  return 3'b101;
        OP_OR:   return 3'b110;
        OP_AND:  return 3'b111;
        default: return 3'b000;
    endcase
endfunction

function automatic logic [31:0] rr_word(input op_e op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    f7 = (op == OP_SUB) ? 7'b0100000 : 7'b0000000;
    return {f7, rs2, rs1, funct3_of(op), rd, `CORE_OPC_OP};
endfunction

function automatic logic [31:0] model_alu(input op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLL:  return a << b[4:0];
        OP_SRL:  return a >> b[4:0];
        default: return {31'b0, $signed(a) < $signed(b)};
    endcase
endfunction

task automatic write_model(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
        model_regs[rd] = value;
    end
endtask

// --------------------
// Stimulus
// --------------------
task automatic send_instr(input logic [31:0] word, input logic [4:0] rd,
                          input logic [31:0] data, input logic ex, input int unsigned gap);
    expect_t e;
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    if (!ex) begin
        exp_instret = exp_instret + 1;
    end
    e.pc      = exp_pc;
    e.rd      = rd;
    e.data    = data;
    e.ex      = ex;
    e.instret = exp_instret;
    // Sampled at the next edge, visible three edges after that
    e.cycle   = cycle_cnt + 5;
    exp_q.push_back(e);
    exp_pc     = exp_pc + 4;
    issued_cnt = issued_cnt + 1;
    gap_cnt    = gap_cnt + gap;
    repeat (gap) begin
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
    end
endtask

task automatic issue_rr(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input int unsigned gap);
    logic [31:0] result;
    result = model_alu(op, model_regs[rs1], model_regs[rs2]);
    send_instr(rr_word(op, rd, rs1, rs2), rd, result, 1'b0, gap);
    write_model(rd, result);
endtask

// Only ADD, AND, OR and XOR have an immediate form here
task automatic issue_imm(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm, input int unsigned gap);
    logic [31:0] result;
    logic [31:0] word;
    result = model_alu(op, model_regs[rs1], {{20{imm[11]}}, imm});
    word   = {imm, rs1, funct3_of(op), rd, `CORE_OPC_OP_IMM};
    send_instr(word, rd, result, 1'b0, gap);
    write_model(rd, result);
endtask

task automatic issue_illegal(input logic [31:0] word, input int unsigned gap);
    send_instr(word, word[11:7], word, 1'b1, gap);
endtask

task automatic start_test(input string name);
    $display("Running %s", name);
    test_cnt = test_cnt + 1;
endtask

task automatic drain_pipeline();
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
        @(negedge clk_i);
    end
    check_value("instret_o", instret_o, exp_instret);
endtask

// --------------------
// Tests
// --------------------
task automatic reset_state_test();
    start_test("reset state and pc sequence");
    @(negedge clk_i);
    check_value("commit_valid_o", 32'(commit_valid_o), 32'd0);
    check_value("instret_o", instret_o, 32'd0);
    issue_imm(OP_ADD, 5'd1, 5'd0, 12'h011, 0);
    issue_imm(OP_ADD, 5'd2, 5'd1, 12'h022, 1);
    issue_imm(OP_XOR, 5'd3, 5'd2, 12'h0f0, 0);
    drain_pipeline();
endtask

task automatic reg_reg_test();
    start_test("register-register operations");
    for (int round = 0; round < 4; round++) begin
        issue_imm(OP_ADD, 5'd1, 5'd0, 12'($urandom), 0);
        issue_imm(OP_XOR, 5'd2, 5'd0, 12'($urandom), 0);
        issue_imm(OP_ADD, 5'd3, 5'd0, 12'($urandom_range(0, 31)), 0);
        // Spread the value over the upper bits
        issue_rr(OP_SLL, 5'd1, 5'd1, 5'd3, 0);
        issue_rr(OP_ADD, 5'd5, 5'd1, 5'd2, 0);
        issue_rr(OP_SUB, 5'd6, 5'd1, 5'd2, 0);
        issue_rr(OP_AND, 5'd7, 5'd1, 5'd2, 0);
        issue_rr(OP_OR, 5'd8, 5'd1, 5'd2, 0);
        issue_rr(OP_XOR, 5'd9, 5'd1, 5'd2, 0);
        issue_rr(OP_SRL, 5'd10, 5'd2, 5'd3, 0);
        issue_rr(OP_SLT, 5'd11, 5'd1, 5'd2, 0);
        issue_rr(OP_SLT, 5'd12, 5'd2, 5'd1, 0);
    end
    drain_pipeline();
endtask

task automatic forwarding_test();
    start_test("dependent chains");
    issue_imm(OP_ADD, 5'd6, 5'd0, 12'($urandom), 0);
    issue_imm(OP_ADD, 5'd7, 5'd0, 12'($urandom), 0);
    issue_imm(OP_ADD, 5'd8, 5'd0, 12'($urandom), 0);
    // Distances 1 and 3
    issue_rr(OP_ADD, 5'd9, 5'd6, 5'd8, 0);
    issue_rr(OP_ADD, 5'd10, 5'd7, 5'd9, 0);
    // Distances 2 and 1
    issue_rr(OP_ADD, 5'd11, 5'd9, 5'd10, 0);
    issue_rr(OP_ADD, 5'd12, 5'd9, 5'd11, 0);
    // Youngest writer of x13 wins
    issue_imm(OP_ADD, 5'd13, 5'd0, 12'h001, 0);
    issue_imm(OP_ADD, 5'd13, 5'd0, 12'h002, 0);
    issue_rr(OP_ADD, 5'd14, 5'd13, 5'd13, 0);
    drain_pipeline();
endtask

task automatic imm_x0_test();
    start_test("negative immediates and x0");
    issue_imm(OP_ADD, 5'd15, 5'd0, 12'hfff, 0);
    issue_imm(OP_AND, 5'd16, 5'd15, 12'h800, 0);
    issue_imm(OP_OR, 5'd17, 5'd0, 12'hff0, 0);
    issue_imm(OP_XOR, 5'd18, 5'd15, 12'h7ff, 0);
    issue_imm(OP_ADD, 5'd0, 5'd0, 12'h005, 0);
    issue_rr(OP_ADD, 5'd0, 5'd15, 5'd15, 0);
    issue_rr(OP_ADD, 5'd19, 5'd0, 5'd0, 2);
    issue_imm(OP_ADD, 5'd20, 5'd0, 12'h000, 0);
    drain_pipeline();
endtask

task automatic illegal_test();
    start_test("illegal encodings");
    issue_imm(OP_ADD, 5'd21, 5'd0, 12'h123, 0);
    issue_illegal({7'h00, 5'd1, 5'd2, 3'b000, 5'd21, 7'b1111111}, 0);
    issue_illegal({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd21, `CORE_OPC_OP}, 0);
    issue_illegal({12'h005, 5'd1, 3'b001, 5'd21, `CORE_OPC_OP_IMM}, 0);
    issue_rr(OP_ADD, 5'd22, 5'd21, 5'd0, 0);
    drain_pipeline();
endtask

task automatic timing_test();
    op_e         op;
    int unsigned gap;
    start_test("commit latency");
    for (int i = 0; i < 24; i++) begin
        op  = op_e'($urandom_range(0, 7));
        gap = (i < 12) ? 0 : $urandom_range(0, 3);
        if ($urandom_range(0, 1) == 1 &&
            (op == OP_ADD || op == OP_AND || op == OP_OR || op == OP_XOR)) begin
            issue_imm(op, 5'($urandom_range(1, 31)), 5'($urandom), 12'($urandom), gap);
        end else begin
            issue_rr(op, 5'($urandom_range(1, 31)), 5'($urandom), 5'($urandom), gap);
        end
    end
    drain_pipeline();
endtask

`endif

// ==== test/tb_core.sv ====
/*
 * Core testbench
 * Drives strobed instructions into the core, keeps a reference
 * register model and checks every commit and its timing
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_core;

    typedef enum {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SLT
    } op_e;

    // One expected commit
    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
        logic                    ex;
        logic [`CORE_XLEN-1:0]   instret;
        logic [31:0]             cycle;
    } expect_t;

    logic                    clk_i;
    logic                    rst_ni;
    logic [`CORE_XLEN-1:0]   boot_addr_i;
    logic                    instr_valid_i;
    core_pkg::instr_t        instr_i;
    logic                    commit_valid_o;
    logic [`CORE_XLEN-1:0]   commit_pc_o;
    logic [`CORE_REG_AW-1:0] commit_rd_o;
    logic [`CORE_XLEN-1:0]   commit_data_o;
    logic                    commit_ex_o;
    logic [`CORE_XLEN-1:0]   instret_o;

    // Reference model
    logic [`CORE_XLEN-1:0] model_regs [`CORE_NR_REGS];
    logic [`CORE_XLEN-1:0] exp_pc;
    logic [`CORE_XLEN-1:0] exp_instret;
    expect_t               exp_q [$];
    expect_t               head;

    int unsigned cycle_cnt;
    int unsigned issued_cnt;
    int unsigned gap_cnt;
    int unsigned test_cnt;

    core_top i_dut (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .boot_addr_i    ( boot_addr_i    ),
        .instr_valid_i  ( instr_valid_i  ),
        .instr_i        ( instr_i        ),
        .commit_valid_o ( commit_valid_o ),
        .commit_pc_o    ( commit_pc_o    ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_data_o  ( commit_data_o  ),
        .commit_ex_o    ( commit_ex_o    ),
        .instret_o      ( instret_o      )
    );

    always #50 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // --------------------
    // Cycle count and timeout
    // --------------------
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > 16 + issued_cnt + gap_cnt + 3 * test_cnt + 50) begin
            $display("Timeout after %0d cycles, commits did not arrive", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // Commit monitor on the falling edge
    always @(negedge clk_i) begin
        if (rst_ni && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Commit at %0t with no instruction outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected commit");
            end else begin
                head = exp_q.pop_front();
                check_value("commit_pc_o", commit_pc_o, head.pc);
                check_value("commit_rd_o", 32'(commit_rd_o), 32'(head.rd));
                check_value("commit_data_o", commit_data_o, head.data);
                check_value("commit_ex_o", 32'(commit_ex_o), 32'(head.ex));
                check_value("instret_o", instret_o, head.instret);
                check_value("commit cycle", cycle_cnt, head.cycle);
            end
        end
    end

    `include "core_tests.svh"

    initial begin
        void'($urandom(17741));
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        boot_addr_i   = 32'h0000_2000;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cycle_cnt     = 0;
        issued_cnt    = 0;
        gap_cnt       = 0;
        test_cnt      = 0;
        exp_pc        = 32'h0000_2000;
        exp_instret   = '0;
        for (int i = 0; i < `CORE_NR_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;

        reset_state_test();
        reg_reg_test();
        forwarding_test();
        imm_x0_test();
        illegal_test();
        timing_test();

        if (exp_q.size() != 0) begin
            $display("%0d commits still outstanding at the end of the run", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "outstanding commits");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== rtl/core_top.sv ====
/*
 * Core top level
 * In-order integer pipeline of fetch, decode, execute and
 * commit around a shared register file
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module core_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [`CORE_XLEN-1:0]   boot_addr_i,
    input  logic                    instr_valid_i,
    input  core_pkg::instr_t        instr_i,
    output logic                    commit_valid_o,
    output logic [`CORE_XLEN-1:0]   commit_pc_o,
    output logic [`CORE_REG_AW-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]   commit_data_o,
    output logic                    commit_ex_o,
    output logic [`CORE_XLEN-1:0]   instret_o
);

    // --------------------
    // Stage links
    // --------------------
    logic                    fetch_valid;
    core_pkg::fetch_entry_t  fetch_entry;
    logic                    issue_valid;
    core_pkg::issue_entry_t  issue_entry;
    logic                    alu_valid;
    core_pkg::result_t       alu_result;
    logic                    ex_valid;
    core_pkg::result_t       ex_result;

    // Register file ports
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]   rs1_data;
    logic [`CORE_XLEN-1:0]   rs2_data;
    logic                    rf_we;
    logic [`CORE_REG_AW-1:0] rf_waddr;
    logic [`CORE_XLEN-1:0]   rf_wdata;

    fetch_stage i_fetch (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .fetch_valid_o ( fetch_valid   ),
        .fetch_entry_o ( fetch_entry   )
    );

    decode_stage i_decode (
        .clk_i              ( clk_i       ),
        .rst_ni             ( rst_ni      ),
        .fetch_valid_i      ( fetch_valid ),
        .fetch_entry_i      ( fetch_entry ),
        .rs1_addr_o         ( rs1_addr    ),
        .rs2_addr_o         ( rs2_addr    ),
        .rs1_data_i         ( rs1_data    ),
        .rs2_data_i         ( rs2_data    ),
        .fwd_alu_valid_i    ( alu_valid   ),
        .fwd_alu_i          ( alu_result  ),
        .fwd_commit_valid_i ( ex_valid    ),
        .fwd_commit_i       ( ex_result   ),
        .issue_valid_o      ( issue_valid ),
        .issue_entry_o      ( issue_entry )
    );

    reg_file i_reg_file (
        .clk_i     ( clk_i    ),
        .rst_ni    ( rst_ni   ),
        .raddr_a_i ( rs1_addr ),
        .raddr_b_i ( rs2_addr ),
        .rdata_a_o ( rs1_data ),
        .rdata_b_o ( rs2_data ),
        .waddr_i   ( rf_waddr ),
        .wdata_i   ( rf_wdata ),
        .we_i      ( rf_we    )
    );

    execute_stage i_execute (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .issue_valid_i ( issue_valid ),
        .issue_entry_i ( issue_entry ),
        .alu_valid_o   ( alu_valid   ),
        .alu_result_o  ( alu_result  ),
        .ex_valid_o    ( ex_valid    ),
        .ex_result_o   ( ex_result   )
    );

    commit_stage i_commit (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .ex_valid_i     ( ex_valid       ),
        .ex_result_i    ( ex_result      ),
        .rf_we_o        ( rf_we          ),
        .rf_waddr_o     ( rf_waddr       ),
        .rf_wdata_o     ( rf_wdata       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_pc_o    ( commit_pc_o    ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_data_o  ( commit_data_o  ),
        .commit_ex_o    ( commit_ex_o    ),
        .instret_o      ( instret_o      )
    );

endmodule

// ==== rtl/commit_stage.sv ====
/*
 * Commit stage
 * Writes results back to the register file, drives the commit
 * port and counts retired instructions
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module commit_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    ex_valid_i,
    input  core_pkg::result_t       ex_result_i,
    output logic                    rf_we_o,
    output logic [`CORE_REG_AW-1:0] rf_waddr_o,
    output logic [`CORE_XLEN-1:0]   rf_wdata_o,
    output logic                    commit_valid_o,
    output logic [`CORE_XLEN-1:0]   commit_pc_o,
    output logic [`CORE_REG_AW-1:0] commit_rd_o,
    output logic [`CORE_XLEN-1:0]   commit_data_o,
    output logic                    commit_ex_o,
    output logic [`CORE_XLEN-1:0]   instret_o
);

    logic retire;

    // Write back in the same edge as the commit port update
    assign rf_we_o    = ex_valid_i && ex_result_i.we;
    assign rf_waddr_o = ex_result_i.rd;
    assign rf_wdata_o = ex_result_i.data;

    assign retire = ex_valid_i && !ex_result_i.illegal;

    // --------------------
    // Commit port
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_o <= 1'b0;
            commit_ex_o    <= 1'b0;
            instret_o      <= '0;
        end else begin
            commit_valid_o <= ex_valid_i;
            commit_ex_o    <= ex_valid_i && ex_result_i.illegal;
            if (retire) begin
                instret_o <= instret_o + `CORE_XLEN'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            commit_pc_o   <= ex_result_i.pc;
            commit_rd_o   <= ex_result_i.rd;
            commit_data_o <= ex_result_i.data;
        end
    end

    // An excepting commit never writes the register file
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rf_we_o |-> !ex_result_i.illegal);

endmodule

// ==== rtl/execute_stage.sv ====
/*
 * Execute stage
 * Integer ALU and the result register towards commit, both
 * also visible to decode for forwarding
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module execute_stage (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   issue_valid_i,
    input  core_pkg::issue_entry_t issue_entry_i,
    output logic                   alu_valid_o,
    output core_pkg::result_t      alu_result_o,
    output logic                   ex_valid_o,
    output core_pkg::result_t      ex_result_o
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_out;

    assign op_a = issue_entry_i.operand_a;
    assign op_b = issue_entry_i.operand_b;

    // --------------------
    // ALU
    // --------------------
    always_comb begin
        case (issue_entry_i.alu_op)
            core_pkg::ALU_ADD: alu_out = op_a + op_b;
            core_pkg::ALU_SUB: alu_out = op_a - op_b;
            core_pkg::ALU_AND: alu_out = op_a & op_b;
            core_pkg::ALU_OR:  alu_out = op_a | op_b;
            core_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            core_pkg::ALU_SLL: alu_out = op_a << op_b[4:0];
            core_pkg::ALU_SRL: alu_out = op_a >> op_b[4:0];
            // Signed compare
            core_pkg::ALU_SLT: alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:           alu_out = '0;
        endcase
    end

    // Combinational result, forwarded to the next instruction
    assign alu_valid_o          = issue_valid_i;
    assign alu_result_o.pc      = issue_entry_i.pc;
    assign alu_result_o.rd      = issue_entry_i.rd;
    assign alu_result_o.we      = issue_entry_i.we;
    assign alu_result_o.illegal = issue_entry_i.illegal;
    // Illegal instructions report their own encoding
    assign alu_result_o.data    = issue_entry_i.illegal ? issue_entry_i.tval : alu_out;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_valid_i;
        end
    end

    // Result register
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            ex_result_o <= alu_result_o;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
/*
 * Register file
 * Integer registers with two combinational read ports and one
 * write port, x0 is never written
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic [`CORE_REG_AW-1:0] raddr_a_i,
    input  logic [`CORE_REG_AW-1:0] raddr_b_i,
    output logic [`CORE_XLEN-1:0]   rdata_a_o,
    output logic [`CORE_XLEN-1:0]   rdata_b_o,
    input  logic [`CORE_REG_AW-1:0] waddr_i,
    input  logic [`CORE_XLEN-1:0]   wdata_i,
    input  logic                    we_i
);

    logic [`CORE_XLEN-1:0] regs_q [`CORE_NR_REGS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Entry 0 stays at its reset value
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== rtl/decode_stage.sv ====
/*
 * Decode stage
 * Decodes the instruction, reads both operands with forwarding
 * from execute and commit, and registers the issue entry
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    fetch_valid_i,
    input  core_pkg::fetch_entry_t  fetch_entry_i,
    output logic [`CORE_REG_AW-1:0] rs1_addr_o,
    output logic [`CORE_REG_AW-1:0] rs2_addr_o,
    input  logic [`CORE_XLEN-1:0]   rs1_data_i,
    input  logic [`CORE_XLEN-1:0]   rs2_data_i,
    input  logic                    fwd_alu_valid_i,
    input  core_pkg::result_t       fwd_alu_i,
    input  logic                    fwd_commit_valid_i,
    input  core_pkg::result_t       fwd_commit_i,
    output logic                    issue_valid_o,
    output core_pkg::issue_entry_t  issue_entry_o
);

    core_pkg::instr_t      instr;
    core_pkg::alu_op_e     dec_op;
    logic                  dec_illegal;
    logic                  dec_use_imm;
    logic [`CORE_XLEN-1:0] imm_sext;
    logic [`CORE_XLEN-1:0] operand_a;
    logic [`CORE_XLEN-1:0] rs2_value;

    // Youngest producer wins and x0 always reads zero
    function automatic logic [`CORE_XLEN-1:0] select_operand(
        input logic [`CORE_REG_AW-1:0] addr,
        input logic [`CORE_XLEN-1:0]   rf_data,
        input logic                    alu_valid,
        input core_pkg::result_t       alu,
        input logic                    cm_valid,
        input core_pkg::result_t       cm
    );
        logic [`CORE_XLEN-1:0] value;
        value = rf_data;
        if (addr == '0) begin
            value = '0;
        end else if (alu_valid && alu.we && alu.rd == addr) begin
            value = alu.data;
        end else if (cm_valid && cm.we && cm.rd == addr) begin
            value = cm.data;
        end
        return value;
    endfunction

    assign instr      = fetch_entry_i.instr;
    assign rs1_addr_o = instr.r.rs1;
    assign rs2_addr_o = instr.r.rs2;
    assign imm_sext   = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    // --------------------
    // Decoder
    // --------------------
    always_comb begin
        dec_op      = core_pkg::ALU_ADD;
        dec_illegal = 1'b0;
        dec_use_imm = 1'b0;
        case (instr.r.opcode)
            `CORE_OPC_OP: begin
                case ({instr.r.funct7, instr.r.funct3})
                    {7'b0000000, 3'b000}: dec_op = core_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: dec_op = core_pkg::ALU_SUB;
                    {7'b0000000, 3'b001}: dec_op = core_pkg::ALU_SLL;
                    {7'b0000000, 3'b010}: dec_op = core_pkg::ALU_SLT;
                    {7'b0000000, 3'b100}: dec_op = core_pkg::ALU_XOR;
                    {7'b0000000, 3'b101}: dec_op = core_pkg::ALU_SRL;
                    {7'b0000000, 3'b110}: dec_op = core_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: dec_op = core_pkg::ALU_AND;
                    default:              dec_illegal = 1'b1;
                endcase
            end
            `CORE_OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                case (instr.i.funct3)
                    3'b000:  dec_op = core_pkg::ALU_ADD;
                    3'b100:  dec_op = core_pkg::ALU_XOR;
                    3'b110:  dec_op = core_pkg::ALU_OR;
                    3'b111:  dec_op = core_pkg::ALU_AND;
                    default: dec_illegal = 1'b1;
                endcase
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    // Operand selection
    assign operand_a = select_operand(instr.r.rs1, rs1_data_i, fwd_alu_valid_i, fwd_alu_i,
                                      fwd_commit_valid_i, fwd_commit_i);
    assign rs2_value = select_operand(instr.r.rs2, rs2_data_i, fwd_alu_valid_i, fwd_alu_i,
                                      fwd_commit_valid_i, fwd_commit_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= fetch_valid_i;
        end
    end

    // Issue entry
    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            issue_entry_o.pc        <= fetch_entry_i.pc;
            issue_entry_o.alu_op    <= dec_op;
            issue_entry_o.rd        <= instr.r.rd;
            issue_entry_o.operand_a <= operand_a;
            issue_entry_o.operand_b <= dec_use_imm ? imm_sext : rs2_value;
            issue_entry_o.we        <= !dec_illegal;
            issue_entry_o.illegal   <= dec_illegal;
            issue_entry_o.tval      <= instr;
        end
    end

    // An illegal result in execute never offers itself for forwarding
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fwd_alu_valid_i && fwd_alu_i.illegal) |-> !fwd_alu_i.we);

endmodule

// ==== rtl/fetch_stage.sv ====
/*
 * Fetch stage
 * Keeps the program counter and captures each strobed
 * instruction together with its pc
 */
`timescale 1ns/1ns
`include "core_settings.svh"

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`CORE_XLEN-1:0] boot_addr_i,
    input  logic                  instr_valid_i,
    input  core_pkg::instr_t      instr_i,
    output logic                  fetch_valid_o,
    output core_pkg::fetch_entry_t fetch_entry_o
);

    logic [`CORE_XLEN-1:0] next_pc_q;

    // Pc of the next accepted instruction, starts at the boot address
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            next_pc_q     <= boot_addr_i;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                next_pc_q <= next_pc_q + `CORE_XLEN'(4);
            end
        end
    end

    // Capture register
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            fetch_entry_o.pc    <= next_pc_q;
            fetch_entry_o.instr <= instr_i;
        end
    end

    // Every captured entry carries a word aligned pc
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_o |-> (fetch_entry_o.pc[1:0] == 2'b00));

endmodule

// ==== rtl/core_pkg.sv ====
/*
 * Core package
 * Instruction formats, ALU operations and the entries that
 * travel between the pipeline stages
 */
`include "core_settings.svh"

package core_pkg;

    // --------------------
    // Instruction formats
    // --------------------
    typedef struct packed {
        logic [6:0]              funct7;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]             imm;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_REG_AW-1:0] rd;
        logic [6:0]              opcode;
    } i_type_t;

    // Same word, seen as register-register or as immediate format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // --------------------
    // Stage entries
    // --------------------
    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        instr_t                instr;
    } fetch_entry_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   operand_a;
        logic [`CORE_XLEN-1:0]   operand_b;
        logic                    we;
        logic                    illegal;
        logic [`CORE_XLEN-1:0]   tval;      // raw instruction word
    } issue_entry_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_XLEN-1:0]   data;
        logic                    we;
        logic                    illegal;
    } result_t;

endpackage

// ==== rtl/core_settings.svh ====
/*
 * Core settings
 * Widths, register count and the major opcodes of the
 * supported RISC-V integer subset
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and instruction word width
`define CORE_XLEN 32

// Integer register file
`define CORE_NR_REGS 32
`define CORE_REG_AW  5

// --------------------
// Major opcodes
// --------------------
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011

`endif
